// ==== design/ooo_pkg.sv ====
/* ooo core shared definitions
   widths, depths, vector types and the operation encoding */
`default_nettype none

package ooo_pkg;

    // instructions offered, renamed and retired per cycle
    localparam int WIDTH = 2;
    localparam int ROB_DEPTH = 8;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    // tags not held by the map table at reset
    localparam int FREE_TAGS = PHYS_REGS - ARCH_REGS;
    // lane 1 register stages
    localparam int MUL_LATENCY = 3;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [15:0] data_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    // 0 to WIDTH slots
    typedef logic [$clog2(WIDTH+1)-1:0] count_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_XOR = 2'd1,
        OP_MUL = 2'd2
    } op_t;

endpackage

`default_nettype wire

// ==== design/dispatch_rename.sv ====
/* decode and rename stage
   maps destinations to free physical tags and grants a prefix of the offered slots */
`timescale 1ns/1ps
`default_nettype none

module dispatch_rename import ooo_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  logic      [WIDTH-1:0]             in_valid,
    input  arch_reg_t [WIDTH-1:0]             in_dest,
    input  op_t       [WIDTH-1:0]             in_op,
    input  data_t     [WIDTH-1:0]             in_a,
    input  data_t     [WIDTH-1:0]             in_b,
    input  count_t                            open_entries,
    input  count_t                            free_count,
    input  phys_tag_t [WIDTH-1:0]             free_tag,
    output count_t                            accept_count,
    output arch_reg_t [WIDTH-1:0]             alloc_dest,
    output phys_tag_t [WIDTH-1:0]             alloc_tag,
    output phys_tag_t [WIDTH-1:0]             alloc_old_tag,
    output logic      [WIDTH-1:0]             issue_valid,
    output phys_tag_t [WIDTH-1:0]             issue_tag,
    output op_t       [WIDTH-1:0]             issue_op,
    output data_t     [WIDTH-1:0]             issue_a,
    output data_t     [WIDTH-1:0]             issue_b
);
    typedef logic [$clog2(FREE_TAGS)-1:0] fl_idx_t;
    typedef logic [$clog2(FREE_TAGS):0] fl_cnt_t;

    // speculative map, arch reg -> newest tag
    phys_tag_t map_table [ARCH_REGS];

    // circular free list
    phys_tag_t fl_tags [FREE_TAGS];
    fl_idx_t fl_head;
    fl_idx_t fl_tail;
    fl_cnt_t fl_count;

    count_t n_valid;
    count_t n_free;
    phys_tag_t [WIDTH-1:0] new_tag;
    phys_tag_t [WIDTH-1:0] old_tag;

    // accept = min(leading valid slots, rob room, tags on hand)
    always_comb begin
        logic gap;
        gap = 1'b0;
        n_valid = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (in_valid[i] && !gap) begin
                n_valid = n_valid + 1'b1;
            end else begin
                gap = 1'b1;
            end
        end
        // tags returned this cycle only count from next cycle
        n_free = (fl_count >= fl_cnt_t'(WIDTH)) ? count_t'(WIDTH) : count_t'(fl_count);
        accept_count = n_valid;
        if (open_entries < accept_count) begin
            accept_count = open_entries;
        end
        if (n_free < accept_count) begin
            accept_count = n_free;
        end
    end

    // tags popped in slot order from the head
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            new_tag[i] = fl_tags[fl_head + fl_idx_t'(i)];
            old_tag[i] = map_table[in_dest[i]];
            // older slot in the same bundle renames first
            for (int k = 0; k < i; k++) begin
                if (in_dest[k] == in_dest[i]) begin
                    old_tag[i] = new_tag[k];
                end
            end
            issue_valid[i] = (i < accept_count);
        end
    end

    assign alloc_dest = in_dest;
    assign alloc_tag = new_tag;
    assign alloc_old_tag = old_tag;
    assign issue_tag = new_tag;
    assign issue_op = in_op;
    assign issue_a = in_a;
    assign issue_b = in_b;

    // free list pop at head, push at tail
    always_ff @(posedge clock) begin
        if (reset) begin
            fl_head <= '0;
            fl_tail <= '0;
            fl_count <= fl_cnt_t'(FREE_TAGS);
            for (int k = 0; k < FREE_TAGS; k++) begin
                fl_tags[k] <= phys_tag_t'(ARCH_REGS + k);
            end
        end else begin
            fl_head <= fl_head + fl_idx_t'(accept_count);
            fl_tail <= fl_tail + fl_idx_t'(free_count);
            fl_count <= fl_count - fl_cnt_t'(accept_count) + fl_cnt_t'(free_count);
            for (int i = 0; i < WIDTH; i++) begin
                if (i < free_count) begin
                    fl_tags[fl_tail + fl_idx_t'(i)] <= free_tag[i];
                end
            end
        end
    end

    // map update, later slot wins on same dest
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_table[r] <= phys_tag_t'(r);
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (i < accept_count) begin
                    map_table[in_dest[i]] <= new_tag[i];
                end
            end
        end
    end

    // commit only hands back tags that were handed out
    a_fl_bound: assert property (@(posedge clock) disable iff (reset)
        fl_count <= fl_cnt_t'(FREE_TAGS));

endmodule

`default_nettype wire

// ==== design/execute_lanes.sv ====
/* execute stage
   lane 0 returns in one cycle, lane 1 in three through a pipelined shift */
`timescale 1ns/1ps
`default_nettype none

module execute_lanes import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic      [WIDTH-1:0] issue_valid,
    input  phys_tag_t [WIDTH-1:0] issue_tag,
    input  op_t       [WIDTH-1:0] issue_op,
    input  data_t     [WIDTH-1:0] issue_a,
    input  data_t     [WIDTH-1:0] issue_b,
    output logic      [WIDTH-1:0] done_valid,
    output phys_tag_t [WIDTH-1:0] done_tag,
    output data_t     [WIDTH-1:0] done_data
);
    // low 16 bits of the result
    function automatic data_t alu(op_t op, data_t a, data_t b);
        data_t r;
        case (op)
            OP_ADD: r = a + b;
            OP_XOR: r = a ^ b;
            OP_MUL: r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // lane 0, single stage
    logic l0_valid;
    phys_tag_t l0_tag;
    data_t l0_data;

    // lane 1, stage 0 takes the fresh result
    logic [MUL_LATENCY-1:0] l1_valid;
    phys_tag_t l1_tag [MUL_LATENCY];
    data_t l1_data [MUL_LATENCY];

    always_ff @(posedge clock) begin
        if (reset) begin
            l0_valid <= 1'b0;
            l1_valid <= '0;
        end else begin
            l0_valid <= issue_valid[0];
            l1_valid <= {l1_valid[MUL_LATENCY-2:0], issue_valid[1]};
        end
    end

    always_ff @(posedge clock) begin
        l0_tag <= issue_tag[0];
        l0_data <= alu(issue_op[0], issue_a[0], issue_b[0]);
        l1_tag[0] <= issue_tag[1];
        l1_data[0] <= alu(issue_op[1], issue_a[1], issue_b[1]);
        // result rides along with its tag
        for (int s = 1; s < MUL_LATENCY; s++) begin
            l1_tag[s] <= l1_tag[s-1];
            l1_data[s] <= l1_data[s-1];
        end
    end

    // lane j feeds completion slot j
    assign done_valid = {l1_valid[MUL_LATENCY-1], l0_valid};
    assign done_tag[0] = l0_tag;
    assign done_tag[1] = l1_tag[MUL_LATENCY-1];
    assign done_data[0] = l0_data;
    assign done_data[1] = l1_data[MUL_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/rob.sv ====
/* reorder buffer
   allocates in order, completes by tag and retires up to two done entries oldest first */
`timescale 1ns/1ps
`default_nettype none

module rob import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  count_t                alloc_count,
    input  arch_reg_t [WIDTH-1:0] alloc_dest,
    input  phys_tag_t [WIDTH-1:0] alloc_tag,
    input  phys_tag_t [WIDTH-1:0] alloc_old_tag,
    input  logic      [WIDTH-1:0] done_valid,
    input  phys_tag_t [WIDTH-1:0] done_tag,
    input  data_t     [WIDTH-1:0] done_data,
    output count_t                open_entries,
    output count_t                retire_count,
    output arch_reg_t [WIDTH-1:0] retire_dest,
    output phys_tag_t [WIDTH-1:0] retire_tag,
    output phys_tag_t [WIDTH-1:0] retire_old_tag,
    output data_t     [WIDTH-1:0] retire_data
);
    typedef logic [$clog2(ROB_DEPTH):0] rob_cnt_t;

    // entry state
    logic ent_valid [ROB_DEPTH];
    logic ent_complete [ROB_DEPTH];
    // entry payload
    arch_reg_t ent_dest [ROB_DEPTH];
    phys_tag_t ent_tag [ROB_DEPTH];
    phys_tag_t ent_old_tag [ROB_DEPTH];
    data_t ent_data [ROB_DEPTH];

    // head is the oldest, tail one past the youngest
    rob_idx_t head;
    rob_idx_t tail;
    rob_cnt_t ent_count;

    rob_idx_t [WIDTH-1:0] ret_idx;
    rob_idx_t [WIDTH-1:0] alloc_idx;
    rob_cnt_t space;

    for (genvar g = 0; g < WIDTH; g++) begin : g_slot
        assign ret_idx[g] = head + rob_idx_t'(g);
        assign alloc_idx[g] = tail + rob_idx_t'(g);
        assign retire_dest[g] = ent_dest[ret_idx[g]];
        assign retire_tag[g] = ent_tag[ret_idx[g]];
        assign retire_old_tag[g] = ent_old_tag[ret_idx[g]];
        assign retire_data[g] = ent_data[ret_idx[g]];
    end

    // retire in order, first incomplete entry blocks the rest
    always_comb begin
        logic stop;
        stop = 1'b0;
        retire_count = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (!stop && ent_valid[ret_idx[i]] && ent_complete[ret_idx[i]]) begin
                retire_count = retire_count + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

    // room after this cycle's retirement, capped at WIDTH
    always_comb begin
        space = rob_cnt_t'(ROB_DEPTH) - ent_count + rob_cnt_t'(retire_count);
        if (space > rob_cnt_t'(WIDTH)) begin
            open_entries = count_t'(WIDTH);
        end else begin
            open_entries = count_t'(space);
        end
    end

    // pointers and count
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            ent_count <= '0;
        end else begin
            head <= head + rob_idx_t'(retire_count);
            tail <= tail + rob_idx_t'(alloc_count);
            ent_count <= ent_count - rob_cnt_t'(retire_count) + rob_cnt_t'(alloc_count);
        end
    end

    // valid and complete bits
    // later writes in the block win: complete, then retire, then alloc
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < ROB_DEPTH; k++) begin
                ent_valid[k] <= 1'b0;
                ent_complete[k] <= 1'b0;
            end
        end else begin
            // tags get reused, so only live entries may match
            for (int k = 0; k < ROB_DEPTH; k++) begin
                for (int j = 0; j < WIDTH; j++) begin
                    if (ent_valid[k] && done_valid[j] && ent_tag[k] == done_tag[j]) begin
                        ent_complete[k] <= 1'b1;
                    end
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (i < retire_count) begin
                    ent_valid[ret_idx[i]] <= 1'b0;
                    ent_complete[ret_idx[i]] <= 1'b0;
                end
            end
            // a full rob can refill a slot freed on this same edge
            for (int j = 0; j < WIDTH; j++) begin
                if (j < alloc_count) begin
                    ent_valid[alloc_idx[j]] <= 1'b1;
                    ent_complete[alloc_idx[j]] <= 1'b0;
                end
            end
        end
    end

    // payload, written on alloc and on completion
    always_ff @(posedge clock) begin
        for (int k = 0; k < ROB_DEPTH; k++) begin
            for (int j = 0; j < WIDTH; j++) begin
                if (ent_valid[k] && done_valid[j] && ent_tag[k] == done_tag[j]) begin
                    ent_data[k] <= done_data[j];
                end
            end
        end
        for (int j = 0; j < WIDTH; j++) begin
            if (j < alloc_count) begin
                ent_dest[alloc_idx[j]] <= alloc_dest[j];
                ent_tag[alloc_idx[j]] <= alloc_tag[j];
                ent_old_tag[alloc_idx[j]] <= alloc_old_tag[j];
            end
        end
    end

    // dispatch must respect the room reported here
    a_alloc_fits: assert property (@(posedge clock) disable iff (reset)
        alloc_count <= open_entries);

    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        ent_count <= rob_cnt_t'(ROB_DEPTH));

endmodule

`default_nettype wire

// ==== design/retire_commit.sv ====
/* result stage
   registers retired slots as commits, updates the arch file and frees old tags */
`timescale 1ns/1ps
`default_nettype none

module retire_commit import ooo_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  count_t                    retire_count,
    input  arch_reg_t [WIDTH-1:0]     retire_dest,
    input  phys_tag_t [WIDTH-1:0]     retire_tag,
    input  phys_tag_t [WIDTH-1:0]     retire_old_tag,
    input  data_t     [WIDTH-1:0]     retire_data,
    output logic      [WIDTH-1:0]     commit_valid,
    output arch_reg_t [WIDTH-1:0]     commit_reg,
    output data_t     [WIDTH-1:0]     commit_data,
    output data_t     [ARCH_REGS-1:0] arch_values,
    output count_t                    free_count,
    output phys_tag_t [WIDTH-1:0]     free_tag
);

    // control side and the arch file
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= '0;
            free_count <= '0;
            arch_values <= '0;
        end else begin
            free_count <= retire_count;
            for (int i = 0; i < WIDTH; i++) begin
                commit_valid[i] <= (i < retire_count);
                // slot order, so slot 1 lands last on a shared reg
                if (i < retire_count) begin
                    arch_values[retire_dest[i]] <= retire_data[i];
                end
            end
        end
    end

    // commit report and tags headed back to the free list
    always_ff @(posedge clock) begin
        commit_reg <= retire_dest;
        commit_data <= retire_data;
        free_tag <= retire_old_tag;
    end

    // rename never reuses the tag it is replacing
    for (genvar g = 0; g < WIDTH; g++) begin : g_tag_chk
        a_new_tag: assert property (@(posedge clock) disable iff (reset)
            (g < retire_count) |-> (retire_tag[g] != retire_old_tag[g]));
    end

endmodule

`default_nettype wire

// ==== design/ooo_core_top.sv ====
/* two-wide out-of-order back end
   rename, two execute lanes, reorder buffer and commit */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top import ooo_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic      [WIDTH-1:0]     in_valid,
    input  arch_reg_t [WIDTH-1:0]     in_dest,
    input  op_t       [WIDTH-1:0]     in_op,
    input  data_t     [WIDTH-1:0]     in_a,
    input  data_t     [WIDTH-1:0]     in_b,
    output count_t                    accept_count,
    output logic      [WIDTH-1:0]     commit_valid,
    output arch_reg_t [WIDTH-1:0]     commit_reg,
    output data_t     [WIDTH-1:0]     commit_data,
    output data_t     [ARCH_REGS-1:0] arch_values
);
    // rename to rob and lanes
    arch_reg_t [WIDTH-1:0] alloc_dest;
    phys_tag_t [WIDTH-1:0] alloc_tag;
    phys_tag_t [WIDTH-1:0] alloc_old_tag;
    logic      [WIDTH-1:0] issue_valid;
    phys_tag_t [WIDTH-1:0] issue_tag;
    op_t       [WIDTH-1:0] issue_op;
    data_t     [WIDTH-1:0] issue_a;
    data_t     [WIDTH-1:0] issue_b;
    // completions
    logic      [WIDTH-1:0] done_valid;
    phys_tag_t [WIDTH-1:0] done_tag;
    data_t     [WIDTH-1:0] done_data;
    // retirement and tag return
    count_t                open_entries;
    count_t                retire_count;
    arch_reg_t [WIDTH-1:0] retire_dest;
    phys_tag_t [WIDTH-1:0] retire_tag;
    phys_tag_t [WIDTH-1:0] retire_old_tag;
    data_t     [WIDTH-1:0] retire_data;
    count_t                free_count;
    phys_tag_t [WIDTH-1:0] free_tag;

    dispatch_rename i_dispatch_rename (
        .clock, .reset, .in_valid, .in_dest, .in_op, .in_a, .in_b,
        .open_entries, .free_count, .free_tag, .accept_count,
        .alloc_dest, .alloc_tag, .alloc_old_tag,
        .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b
    );

    execute_lanes i_execute_lanes (
        .clock, .reset, .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b,
        .done_valid, .done_tag, .done_data
    );

    // grant count doubles as the rob allocation count
    rob i_rob (
        .clock, .reset, .alloc_count(accept_count), .alloc_dest, .alloc_tag, .alloc_old_tag,
        .done_valid, .done_tag, .done_data, .open_entries, .retire_count,
        .retire_dest, .retire_tag, .retire_old_tag, .retire_data
    );

    retire_commit i_retire_commit (
        .clock, .reset, .retire_count, .retire_dest, .retire_tag, .retire_old_tag,
        .retire_data, .commit_valid, .commit_reg, .commit_data, .arch_values,
        .free_count, .free_tag
    );

endmodule

`default_nettype wire

// ==== dv/ooo_core_tb.sv ====
/* ooo core testbench
   streams bundles from the case file and checks commits against an in-order model */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    logic clock;
    logic reset;
    logic      [WIDTH-1:0]     in_valid;
    arch_reg_t [WIDTH-1:0]     in_dest;
    op_t       [WIDTH-1:0]     in_op;
    data_t     [WIDTH-1:0]     in_a;
    data_t     [WIDTH-1:0]     in_b;
    count_t                    accept_count;
    logic      [WIDTH-1:0]     commit_valid;
    arch_reg_t [WIDTH-1:0]     commit_reg;
    data_t     [WIDTH-1:0]     commit_data;
    data_t     [ARCH_REGS-1:0] arch_values;

    // instructions not yet granted in program order
    arch_reg_t pend_dest [$];
    logic [1:0] pend_op [$];
    data_t pend_a [$];
    data_t pend_b [$];
    // granted and waiting for commit in program order
    arch_reg_t exp_dest [$];
    data_t exp_val [$];
    data_t shadow [ARCH_REGS];
    data_t file_final [ARCH_REGS];
    logic have_final;

    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_fail = 0;
    int total = 0;
    int committed = 0;
    int accepted_total = 0;
    int offered_now = 0;
    logic stall_seen = 1'b0;
    int seed = 32'hc285;
    int cycle_count = 0;
    int cycle_limit = 200;

    ooo_core_top i_ooo_core_top (
        .clock, .reset, .in_valid, .in_dest, .in_op, .in_a, .in_b,
        .accept_count, .commit_valid, .commit_reg, .commit_data, .arch_values
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // op applied to the immediates and cut to the low half
    function automatic data_t expected_result(input logic [1:0] op, input data_t a,
                                              input data_t b);
        logic [31:0] wide;
        case (op)
            2'd0: wide = a + b;
            2'd1: wide = {16'h0, a ^ b};
            default: wide = a * b;
        endcase
        return wide[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        err_count++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: clean", name);
        end else begin
            test_fail++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // B lines hold two instructions, F line the final register values
    task automatic load_cases();
        int fd;
        int n;
        string word;
        string rest;
        logic [15:0] f [8];
        fd = $fopen("dv/ooo_cases.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open dv/ooo_cases.txt");
            return;
        end
        while ($fscanf(fd, " %s", word) == 1) begin
            if (word == "#") begin
                n = $fgets(rest, fd);
            end else if (word == "B") begin
                n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 8) begin
                    report_problem("short bundle line in the case file");
                end
                for (int s = 0; s < 2; s++) begin
                    pend_dest.push_back(arch_reg_t'(f[4*s]));
                    pend_op.push_back(f[4*s+1][1:0]);
                    pend_a.push_back(f[4*s+2]);
                    pend_b.push_back(f[4*s+3]);
                end
            end else if (word == "F") begin
                n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                            file_final[0], file_final[1], file_final[2], file_final[3],
                            file_final[4], file_final[5], file_final[6], file_final[7]);
                have_final = (n == 8);
            end else begin
                report_problem("unknown record in the case file");
            end
        end
        $fclose(fd);
        total = pend_dest.size();
    endtask

    // two oldest pending unless this is an idle gap
    task automatic drive_bundle();
        int offered;
        logic gap;
        gap = ($unsigned($random(seed)) % 8) == 0;
        offered = (pend_dest.size() < WIDTH) ? pend_dest.size() : WIDTH;
        if (gap) begin
            offered = 0;
        end
        for (int i = 0; i < WIDTH; i++) begin
            in_valid[i] = (i < offered);
            in_dest[i] = (i < pend_dest.size()) ? pend_dest[i] : arch_reg_t'(0);
            in_op[i] = (i < pend_dest.size()) ? op_t'(pend_op[i]) : OP_ADD;
            in_a[i] = (i < pend_dest.size()) ? pend_a[i] : data_t'(0);
            in_b[i] = (i < pend_dest.size()) ? pend_b[i] : data_t'(0);
        end
        offered_now = offered;
    endtask

    // called at the rising edge before the flops move
    task automatic sample_cycle();
        int granted;
        granted = int'(accept_count);
        // commits belong to earlier grants and go first
        for (int i = 0; i < WIDTH; i++) begin
            if (commit_valid[i]) begin
                if (accepted_total == 0) begin
                    report_problem("commit seen before any instruction was accepted");
                end
                if (exp_dest.size() == 0) begin
                    report_problem("commit with no instruction outstanding");
                end else begin
                    check_value($sformatf("commit_reg[%0d]", i), commit_reg[i], exp_dest[0]);
                    check_value($sformatf("commit_data[%0d]", i), commit_data[i], exp_val[0]);
                    shadow[exp_dest[0]] = exp_val[0];
                    void'(exp_dest.pop_front());
                    void'(exp_val.pop_front());
                    committed++;
                end
            end
        end
        if (granted > offered_now) begin
            report_problem($sformatf("accept_count %0d is above the %0d slots offered",
                                     granted, offered_now));
        end
        if (offered_now == WIDTH && granted < WIDTH) begin
            stall_seen = 1'b1;
        end
        for (int k = 0; k < granted && k < offered_now; k++) begin
            exp_dest.push_back(pend_dest[0]);
            exp_val.push_back(expected_result(pend_op[0], pend_a[0], pend_b[0]));
            void'(pend_dest.pop_front());
            void'(pend_op.pop_front());
            void'(pend_a.pop_front());
            void'(pend_b.pop_front());
            accepted_total++;
        end
    endtask

    initial begin : main
        int errs;
        reset = 1'b1;
        have_final = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) begin
            shadow[r] = '0;
            file_final[r] = '0;
        end
        drive_bundle();
        in_valid = '0;
        load_cases();
        // about 20 cycles per instruction is far beyond the worst stall
        cycle_limit = 20 * total + 200;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        errs = err_count;
        for (int r = 0; r < ARCH_REGS; r++) begin
            check_value($sformatf("arch_values[%0d]", r), arch_values[r], 32'h0);
        end
        check_value("commit_valid", commit_valid, 32'h0);
        finish_test("reset_state", errs);

        errs = err_count;
        if (total == 0) begin
            report_problem("case file holds no instructions");
        end
        while (committed < total) begin
            drive_bundle();
            @(posedge clock);
            sample_cycle();
            @(negedge clock);
        end
        // core stays quiet once drained
        in_valid = '0;
        offered_now = 0;
        repeat (8) begin
            @(posedge clock);
            check_value("commit_valid", commit_valid, 32'h0);
            check_value("accept_count", accept_count, 32'h0);
        end
        finish_test("commit_stream", errs);

        errs = err_count;
        if (!stall_seen) begin
            report_problem("dispatch never stalled on a full rob or empty free list");
        end
        finish_test("back_pressure", errs);

        errs = err_count;
        for (int r = 0; r < ARCH_REGS; r++) begin
            check_value($sformatf("arch_values[%0d]", r), arch_values[r], shadow[r]);
            if (have_final) begin
                check_value($sformatf("file r%0d", r), arch_values[r], file_final[r]);
            end
        end
        if (!have_final) begin
            report_problem("case file has no final register line");
        end
        finish_test("final_registers", errs);

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 test_count, test_fail, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // hard stop if commits never drain
    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions committed",
                 cycle_count, committed, total);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ooo_pkg.sv
design/dispatch_rename.sv
design/execute_lanes.sv
design/rob.sv
design/retire_commit.sv
design/ooo_core_top.sv
dv/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - target: rtl
    files:
      - design/ooo_pkg.sv
      - design/dispatch_rename.sv
      - design/execute_lanes.sv
      - design/rob.sv
      - design/retire_commit.sv
      - design/ooo_core_top.sv

  - target: test
    files:
      - dv/ooo_core_tb.sv

// ==== dv/ooo_cases.txt ====
# B dest0 op0 a0 b0 dest1 op1 a1 b1 (hex), op 0 add, 1 xor, 2 mul, slot 0 older
# F expected r0 r1 r2 r3 r4 r5 r6 r7 after all commits (hex)
B 1 0 0003 0004 2 2 0005 0006
B 3 1 00ff 0f0f 4 2 0100 0100
B 5 0 ffff 0002 5 2 0003 0007
B 6 2 1234 0010 7 2 00ff 00ff
B 0 0 0001 0001 1 2 0002 0003
B 2 0 0010 0020 3 2 0004 0005
B 4 1 aaaa 5555 5 2 0006 0007
B 1 2 0003 0003 2 2 0004 0004
B 3 2 0005 0005 4 2 0006 0006
B 5 2 0007 0007 6 2 0008 0008
B 6 0 0100 0001 7 2 0008 0009
B 0 1 0f0f 00ff 1 2 000a 000b
B 2 0 7fff 0001 3 2 000c 000d
B 4 0 0002 0002 5 2 000e 000f
B 6 1 1111 2222 7 2 0010 0011
B 0 0 0005 0005 0 2 0012 0013
B 1 1 0000 0000 2 2 0014 0015
B 3 0 8000 8000 4 2 ffff ffff
B 5 2 0100 0101 6 2 0016 0017
B 7 0 0020 0030 1 2 0018 0019
B 2 1 abcd 1234 3 2 001a 001b
F 0156 0258 b9f9 02be 0001 0100 01fa 0050
